// File: modsq_arith_pkg.sv
package modsq_arith_pkg;

    localparam int NUM_WORDS   = 4;
    localparam int WORD_LEN    = 16;
    localparam int OPERAND_LEN = NUM_WORDS * WORD_LEN;
    localparam int NUM_COLS    = 2 * NUM_WORDS - 1;

    // Odd modulus between 2^62 and 2^63, so 2^64 < 4 * MODULUS
    localparam logic [OPERAND_LEN-1:0] MODULUS = 64'h5A3C_9E17_D2B4_8F63;

    localparam int CHUNK_LEN  = 6;
    localparam int NUM_CHUNKS = (OPERAND_LEN + CHUNK_LEN - 1) / CHUNK_LEN;
    localparam int MAX_MULT   = 4;

    // A column holds at most NUM_WORDS products of two words
    localparam int COL_EXTRA = $clog2(NUM_WORDS);
    localparam int COL_WORDS = (2 * WORD_LEN + COL_EXTRA + WORD_LEN - 1) / WORD_LEN;

    // Table sum stays below 2^64 + 12 * MODULUS, which is under 7 * 2^64
    localparam int CARRY_LEN = 3;

    typedef logic [WORD_LEN-1:0] word_t;
    typedef word_t [NUM_WORDS-1:0] operand_t;

    typedef struct packed {
        logic [OPERAND_LEN-1:0] high;
        logic [OPERAND_LEN:0]   low;     // Bit 64 is the carry out of the low half
    } square_t;

    // Value times 2^shift modulo MODULUS, by repeated doubling
    function automatic operand_t shift_mod(logic [OPERAND_LEN-1:0] value, int shift);
        logic [OPERAND_LEN:0] acc;
        acc = {1'b0, value};
        if (acc >= MODULUS) begin
            acc = acc - MODULUS;
        end
        for (int i = 0; i < shift; i++) begin
            acc = acc << 1;
            if (acc >= MODULUS) begin
                acc = acc - MODULUS;
            end
        end
        return acc[OPERAND_LEN-1:0];
    endfunction

    // Weight of chunk k sits at bit 64 + 6k of the square
    function automatic operand_t high_table_entry(int k, int v);
        return shift_mod(OPERAND_LEN'(v), OPERAND_LEN + CHUNK_LEN * k);
    endfunction

    function automatic operand_t carry_table_entry(int c);
        return shift_mod(OPERAND_LEN'(c), OPERAND_LEN);
    endfunction

endpackage

// File: modsq_ctrl_pkg.sv
package modsq_ctrl_pkg;

    localparam int ITER_LEN = 32;

    // Four calculate states make one squaring pass
    typedef enum logic [2:0] {
        idle,
        load,
        calc0,
        calc1,
        calc2,
        calc3,
        finish
    } seq_state_e;

    typedef struct packed {
        logic                      start;
        modsq_arith_pkg::operand_t operand;
        logic [ITER_LEN-1:0]       iterations;   // Zero runs a single pass
    } sq_request_t;

    typedef struct packed {
        logic                      done;
        modsq_arith_pkg::operand_t residue;
    } sq_result_t;

endpackage

// File: column_multiplier.sv
`timescale 1ns/1ns

module column_multiplier (
    input  modsq_arith_pkg::word_t pair_a [modsq_arith_pkg::NUM_WORDS-1],
    input  modsq_arith_pkg::word_t pair_b [modsq_arith_pkg::NUM_WORDS-1],
    input  int                     pair_count,
    input  logic                   doubled,
    output modsq_arith_pkg::word_t col_words [modsq_arith_pkg::COL_WORDS]
);
    import modsq_arith_pkg::*;

    // pair_count is the number of ordered pairs (i, j) in the column.
    // Entries below pair_count / 2 are off-diagonal, and when pair_count is
    // odd the next entry holds the diagonal pair.

    (* use_dsp = "yes" *) logic [2*WORD_LEN-1:0] products [NUM_WORDS-1];
    logic [COL_WORDS*WORD_LEN-1:0] col_sum;

    always_comb begin
        for (int e = 0; e < NUM_WORDS - 1; e++) begin
            products[e] = pair_a[e] * pair_b[e];
        end
    end

    always_comb begin
        col_sum = '0;
        for (int e = 0; e < NUM_WORDS - 1; e++) begin
            if (e < pair_count / 2) begin
                col_sum += doubled ? {products[e], 1'b0} : products[e];  // a_i*a_j and a_j*a_i
            end
            else if (e < (pair_count + 1) / 2) begin
                col_sum += products[e];                 // Square of one word
            end
        end
    end

    // Word w of the column lands at word offset column + w of the square
    always_comb begin
        for (int w = 0; w < COL_WORDS; w++) begin
            col_words[w] = col_sum[w*WORD_LEN +: WORD_LEN];
        end
    end

endmodule

// File: square_accumulator.sv
`timescale 1ns/1ns

module square_accumulator (
    input  logic                      clk,
    input  modsq_arith_pkg::operand_t operand,
    output modsq_arith_pkg::square_t  square
);
    import modsq_arith_pkg::*;

    word_t pair_a    [NUM_COLS][NUM_WORDS-1];
    word_t pair_b    [NUM_COLS][NUM_WORDS-1];
    word_t col_words [NUM_COLS][COL_WORDS];
    word_t col_q     [NUM_COLS][COL_WORDS];

    logic [WORD_LEN+1:0]      word_sum [2*NUM_WORDS];
    logic [2*OPERAND_LEN-1:0] sum_lo;
    logic [2*OPERAND_LEN-1:0] sum_hi;

    for (genvar c = 0; c < NUM_COLS; c++) begin : g_col
        localparam int FIRST      = (c < NUM_WORDS) ? 0 : c - NUM_WORDS + 1;
        localparam int PAIR_COUNT = c - 2 * FIRST + 1;

        for (genvar e = 0; e < NUM_WORDS - 1; e++) begin : g_pair
            if (e < (PAIR_COUNT + 1) / 2) begin : g_used
                assign pair_a[c][e] = operand[FIRST + e];
                assign pair_b[c][e] = operand[c - FIRST - e];
            end
            else begin : g_unused
                assign pair_a[c][e] = '0;
                assign pair_b[c][e] = '0;
            end
        end

        column_multiplier u_column_multiplier (
            .pair_a     (pair_a[c]),
            .pair_b     (pair_b[c]),
            .pair_count (PAIR_COUNT),
            .doubled    (PAIR_COUNT > 1),
            .col_words  (col_words[c])
        );
    end

    always_ff @(posedge clk) begin
        col_q <= col_words;
    end

    // At most three column words overlap at one word offset
    always_comb begin
        for (int k = 0; k < 2 * NUM_WORDS; k++) begin
            word_sum[k] = '0;
        end
        for (int c = 0; c < NUM_COLS; c++) begin
            for (int w = 0; w < COL_WORDS; w++) begin
                if (c + w < 2 * NUM_WORDS) begin
                    word_sum[c + w] += col_q[c][w];
                end
            end
        end
    end

    // The square fits in 128 bits, so the carry of the top word is always zero
    always_comb begin
        sum_hi = '0;
        for (int k = 0; k < 2 * NUM_WORDS; k++) begin
            sum_lo[k*WORD_LEN +: WORD_LEN] = word_sum[k][WORD_LEN-1:0];
        end
        for (int k = 1; k < 2 * NUM_WORDS; k++) begin
            sum_hi[k*WORD_LEN +: WORD_LEN] = WORD_LEN'(word_sum[k-1][WORD_LEN+1:WORD_LEN]);
        end
    end

    always_ff @(posedge clk) begin
        square.high <= sum_lo[2*OPERAND_LEN-1:OPERAND_LEN] + sum_hi[2*OPERAND_LEN-1:OPERAND_LEN];
        square.low  <= sum_lo[OPERAND_LEN-1:0] + sum_hi[OPERAND_LEN-1:0];
    end

endmodule

// File: residue_reducer.sv
`timescale 1ns/1ns

module residue_reducer (
    input  logic                      clk,
    input  modsq_arith_pkg::square_t  square,
    output modsq_arith_pkg::operand_t reduced
);
    import modsq_arith_pkg::*;

    operand_t high_rom  [NUM_CHUNKS][2**CHUNK_LEN];
    operand_t carry_rom [2**CARRY_LEN];

    logic [CHUNK_LEN*NUM_CHUNKS-1:0]  high_ext;
    logic [OPERAND_LEN+CARRY_LEN-1:0] wide_sum;
    logic [OPERAND_LEN-1:0]           part_q;
    logic [CARRY_LEN-1:0]             carry_q;
    logic [OPERAND_LEN:0]             total;
    logic [OPERAND_LEN+1:0]           diff;

    for (genvar k = 0; k < NUM_CHUNKS; k++) begin : g_high_rom
        for (genvar v = 0; v < 2**CHUNK_LEN; v++) begin : g_entry
            localparam operand_t ENTRY = high_table_entry(k, v);
            assign high_rom[k][v] = ENTRY;
        end
    end

    for (genvar c = 0; c < 2**CARRY_LEN; c++) begin : g_carry_rom
        localparam operand_t ENTRY = carry_table_entry(c);
        assign carry_rom[c] = ENTRY;
    end

    assign high_ext = (CHUNK_LEN*NUM_CHUNKS)'(square.high);

    // Fold every chunk of the high half and the low carry back below 2^64 weight
    always_comb begin
        wide_sum = (OPERAND_LEN+CARRY_LEN)'(square.low[OPERAND_LEN-1:0]);
        if (square.low[OPERAND_LEN]) begin
            wide_sum += (OPERAND_LEN+CARRY_LEN)'(carry_rom[1]);
        end
        for (int k = 0; k < NUM_CHUNKS; k++) begin
            wide_sum += (OPERAND_LEN+CARRY_LEN)'(high_rom[k][high_ext[k*CHUNK_LEN +: CHUNK_LEN]]);
        end
    end

    always_ff @(posedge clk) begin
        part_q  <= wide_sum[OPERAND_LEN-1:0];
        carry_q <= wide_sum[OPERAND_LEN+CARRY_LEN-1:OPERAND_LEN];
    end

    assign total = {1'b0, part_q} + (OPERAND_LEN+1)'(carry_rom[carry_q]);

    // Total is below 2^64 + MODULUS, so at most four subtractions are needed
    always_comb begin
        reduced = total[OPERAND_LEN-1:0];
        diff    = '0;
        for (int m = 1; m <= MAX_MULT; m++) begin
            diff = {1'b0, total} - (OPERAND_LEN+2)'(m) * (OPERAND_LEN+2)'(MODULUS);
            if (!diff[OPERAND_LEN+1]) begin
                reduced = diff[OPERAND_LEN-1:0];                 // Larger multiple still fits
            end
        end
    end

endmodule

// File: squaring_sequencer.sv
`timescale 1ns/1ns

module squaring_sequencer (
    input  logic                        clk,
    input  logic                        reset,
    input  modsq_ctrl_pkg::sq_request_t request,
    input  modsq_arith_pkg::operand_t   reduced,
    output modsq_arith_pkg::operand_t   operand,
    output modsq_ctrl_pkg::sq_result_t  result,
    output logic                        busy
);
    import modsq_arith_pkg::*;
    import modsq_ctrl_pkg::*;

    seq_state_e          state;
    seq_state_e          state_next;
    logic [ITER_LEN-1:0] target_q;
    logic [ITER_LEN-1:0] count_q;
    operand_t            operand_q;
    logic                accept;
    logic                last_pass;

    assign accept    = request.start && (state == idle);
    assign last_pass = (count_q == target_q - 1'b1);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= idle;
        end
        else begin
            state <= state_next;
        end
    end

    always_comb begin
        case (state)
            idle:    state_next = accept ? load : idle;
            load:    state_next = calc0;
            calc0:   state_next = calc1;
            calc1:   state_next = calc2;
            calc2:   state_next = calc3;
            calc3:   state_next = last_pass ? finish : calc0;
            default: state_next = idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset || accept) begin
            count_q <= '0;
        end
        else if (state == calc3) begin
            count_q <= count_q + 1'b1;
        end
    end

    // The operand stays put for the four cycles the pipeline needs
    always_ff @(posedge clk) begin
        if (accept) begin
            operand_q <= request.operand;
            target_q  <= (request.iterations == '0) ? ITER_LEN'(1) : request.iterations;
        end
        else if (state == calc3) begin
            operand_q <= reduced;
        end
    end

    assign operand        = operand_q;
    assign result.done    = (state == finish);
    assign result.residue = operand_q;                  // Holds until the next request
    assign busy           = (state != idle);

endmodule

// File: modular_squarer.sv
`timescale 1ns/1ns

module modular_squarer (
    input  logic                        clk,
    input  logic                        reset,
    input  modsq_ctrl_pkg::sq_request_t request,
    output modsq_ctrl_pkg::sq_result_t  result,
    output logic                        busy
);
    import modsq_arith_pkg::*;

    operand_t operand;
    operand_t reduced;
    square_t  square;

    squaring_sequencer u_squaring_sequencer (
        .clk     (clk),
        .reset   (reset),
        .request (request),
        .reduced (reduced),
        .operand (operand),
        .result  (result),
        .busy    (busy)
    );

    square_accumulator u_square_accumulator (.clk(clk), .operand(operand), .square(square));

    residue_reducer u_residue_reducer (.clk(clk), .square(square), .reduced(reduced));

endmodule

// File: tb_modular_squarer.sv
`timescale 1ns/1ns

module tb_modular_squarer;
    import modsq_arith_pkg::*;
    import modsq_ctrl_pkg::*;

    localparam int IDLE_TIMEOUT = 400;

    logic        clk;
    logic        reset;
    sq_request_t request;
    sq_result_t  result;
    logic        busy;
    logic        result_valid;
    int          error_count;

    modular_squarer dut_i (
        .clk     (clk),
        .reset   (reset),
        .request (request),
        .result  (result),
        .busy    (busy)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        if (reset) begin
            result_valid <= 1'b0;
        end
        else if (result.done) begin
            result_valid <= 1'b1;                       // A residue exists from here on
        end
    end

    task automatic report_mismatch(string test, logic [63:0] expected, logic [63:0] actual);
        error_count++;
        $display("[FAIL] %s: expected %h, actual %h", test, expected, actual);
        $display("CHECKS FAILED");
        $fatal(1, "Value mismatch in %s", test);
    endtask

    task automatic report_error(string what);
        error_count++;
        $display("%s", what);
        $display("CHECKS FAILED");
        $fatal(1, "Run stopped");
    endtask

    assert property (@(posedge clk) disable iff (reset)
        result.done |-> result.residue < MODULUS)
    else report_mismatch("residue_below_modulus", MODULUS, $sampled(result.residue));

    assert property (@(posedge clk) disable iff (reset) result.done |=> !result.done)
    else report_error("Done stayed high for more than one cycle");

    assert property (@(posedge clk) disable iff (reset) busy && !result.done |=> busy)
    else report_error("Busy dropped before done was given");

    // Residue is frozen from done until a start is seen while idle
    assert property (@(posedge clk) disable iff (reset)
        result.done || (result_valid && !busy && !request.start) |=> $stable(result.residue))
    else report_error("Residue changed between done and the next accepted start");

    function automatic logic [63:0] golden_residue(logic [63:0] value, int passes);
        logic [127:0] square;
        logic [63:0]  acc;
        acc = value;
        for (int i = 0; i < passes; i++) begin
            square = 128'(acc) * 128'(acc);
            acc    = 64'(square % 128'(MODULUS));
        end
        return acc;
    endfunction

    task automatic wait_idle(string test);
        int waited;
        waited = 0;
        while (busy) begin
            @(posedge clk);
            waited++;
            if (waited > IDLE_TIMEOUT) begin
                report_error($sformatf("%s: busy never dropped before the request", test));
            end
        end
    endtask

    // A nonzero intrude_at drives a second start that many cycles after acceptance
    task automatic run_request(string test, operand_t value, logic [ITER_LEN-1:0] iterations,
                               int intrude_at);
        int          passes;
        int          cycles;
        logic [63:0] expected;
        passes   = (iterations == '0) ? 1 : int'(iterations);
        expected = golden_residue(value, passes);
        wait_idle(test);
        request <= '{start: 1'b1, operand: value, iterations: iterations};
        @(posedge clk);                                 // Accepting edge
        request.start <= 1'b0;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            assert (busy) else report_mismatch({test, " busy"}, 1, busy);
            if (cycles == intrude_at) begin
                request <= '{start: 1'b1, operand: ~value, iterations: ITER_LEN'(3)};
            end
            else begin
                request.start <= 1'b0;
            end
            if (cycles > 4 * passes + 40) begin
                report_error($sformatf("%s: done never came after %0d cycles", test, cycles));
            end
        end while (!result.done);
        assert (cycles == 4 * passes + 2)
        else report_mismatch({test, " latency"}, 4 * passes + 2, cycles);
        assert (result.residue == expected) else report_mismatch(test, expected, result.residue);
        repeat (3) @(posedge clk);
        assert (result.residue == expected)
        else report_mismatch({test, " hold"}, expected, result.residue);
    endtask

    initial begin
        operand_t            value;
        logic [ITER_LEN-1:0] iters;
        clk         = 1'b0;
        reset       = 1'b1;
        request     = '0;
        error_count = 0;
        void'($urandom(14235));
        repeat (8) @(posedge clk);
        reset <= 1'b0;

        repeat (16) begin
            @(posedge clk);
            assert (!busy) else report_mismatch("idle_busy", 0, busy);
            assert (!result.done) else report_mismatch("idle_done", 0, result.done);
        end

        run_request("square_zero", '0, ITER_LEN'(1), 0);
        run_request("square_one", 64'd1, ITER_LEN'(1), 0);
        run_request("square_modulus_minus_one", MODULUS - 1, ITER_LEN'(1), 0);
        for (int i = 0; i < 8; i++) begin
            value = {$urandom, $urandom} % MODULUS;
            run_request("square_random", value, ITER_LEN'(1), 0);
        end

        for (int i = 0; i < 4; i++) begin
            iters = 2 + $urandom % 39;
            run_request("all_ones_multi", '1, iters, 0);   // Every word 0xFFFF
        end
        for (int i = 0; i < 8; i++) begin
            value = {$urandom, $urandom} % MODULUS;
            iters = 2 + $urandom % 39;
            run_request("random_multi", value, iters, 0);
        end

        value = {$urandom, $urandom} % MODULUS;
        run_request("start_while_busy", value, ITER_LEN'(7), 9);
        value = {$urandom, $urandom} % MODULUS;
        run_request("zero_count", value, ITER_LEN'(0), 0);

        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end
        else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: src.f
modsq_arith_pkg.sv
modsq_ctrl_pkg.sv
column_multiplier.sv
square_accumulator.sv
residue_reducer.sv
squaring_sequencer.sv
modular_squarer.sv
tb_modular_squarer.sv

// File: Bender.yml
package:
  name: modular_squarer

sources:
  - modsq_arith_pkg.sv
  - modsq_ctrl_pkg.sv
  - column_multiplier.sv
  - square_accumulator.sv
  - residue_reducer.sv
  - squaring_sequencer.sv
  - modular_squarer.sv
  - target: simulation
    files:
      - tb_modular_squarer.sv
